/* cpuControlPkg.sv */
`default_nettype none

package cpuControlPkg;

    localparam int InstrWidthDefault = 32; // one word on the single bus
    localparam int OpcodeWidth = 5;        // opcode field in the top bits
    localparam int StepWidth = 3;          // longest class has 5 execute steps

    typedef logic [OpcodeWidth-1:0] opcodeT; // raw opcode field
    typedef logic [StepWidth-1:0] stepT;     // execute step, first one is 0

    typedef enum logic [2:0] {
        phaseReset,  // pc cleared, run raised
        phaseFetch0, // pc to mar, pc incremented
        phaseFetch1, // memory read into mdr
        phaseFetch2, // mdr to ir, opcode valid
        phaseExec,   // class specific steps
        phaseHalt    // parked until reset
    } phaseT;

    typedef enum logic [3:0] {
        classAluReg,   // ra = rb op rc
        classAluImm,   // ra = rb op c
        classDivide,   // z pair to hi and lo
        classMultiply, // low half back to ra
        classUnary,    // neg and not
        classBranch,   // conditional, uses con flag
        classJumpReg,  // pc = ra
        classJumpLink, // save pc, then pc = ra
        classLoad,     // ld and ldi
        classStore,
        classMoveHi,
        classMoveLo,
        classHalt,
        classNone      // unknown opcode
    } instrClassT;

    typedef enum logic [3:0] {
        aluNone,
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluRor,
        aluRol,
        aluShr,
        aluShra, // sign-filling shift
        aluShl,
        aluDiv,
        aluMul,
        aluNeg,
        aluNot
    } aluOpT;

    // memory
    localparam opcodeT opLd   = 5'b00000;
    localparam opcodeT opLdi  = 5'b00001;
    localparam opcodeT opSt   = 5'b00010;
    // register-register alu
    localparam opcodeT opAdd  = 5'b00011;
    localparam opcodeT opSub  = 5'b00100;
    localparam opcodeT opAnd  = 5'b00101;
    localparam opcodeT opOr   = 5'b00110;
    localparam opcodeT opRor  = 5'b00111;
    localparam opcodeT opRol  = 5'b01000;
    localparam opcodeT opShr  = 5'b01001;
    localparam opcodeT opShra = 5'b01010;
    localparam opcodeT opShl  = 5'b01011;
    // immediate alu
    localparam opcodeT opAddi = 5'b01100;
    localparam opcodeT opAndi = 5'b01101;
    localparam opcodeT opOri  = 5'b01110;
    // hi/lo producers and unary ops
    localparam opcodeT opDiv  = 5'b01111;
    localparam opcodeT opMul  = 5'b10000;
    localparam opcodeT opNeg  = 5'b10001;
    localparam opcodeT opNot  = 5'b10010;
    // control flow
    localparam opcodeT opBr   = 5'b10011;
    localparam opcodeT opJal  = 5'b10100;
    localparam opcodeT opJr   = 5'b10101;
    localparam opcodeT opMflo = 5'b11000;
    localparam opcodeT opMfhi = 5'b11001;
    localparam opcodeT opHalt = 5'b11011;

endpackage

`default_nettype wire

/* opcodeDecoder.sv */
`timescale 1ns/100ps
`default_nettype none

module opcodeDecoder import cpuControlPkg::*; #(
    parameter int InstrWidth = InstrWidthDefault
) (
    input  wire logic [InstrWidth-1:0] instruction, // word from mdr during fetch2
    output instrClassT                 instrClass,
    output aluOpT                      decodedAluOp
);

    opcodeT opcode;

    assign opcode = instruction[InstrWidth-1 -: OpcodeWidth]; // top bits only

    // class picks the step pattern
    always_comb begin
        case (opcode)
            opAdd, opSub, opAnd, opOr,
            opRor, opRol, opShr, opShra, opShl:
                instrClass = classAluReg;
            opAddi, opAndi, opOri:
                instrClass = classAluImm;
            opDiv:
                instrClass = classDivide;
            opMul:
                instrClass = classMultiply;
            opNeg, opNot:
                instrClass = classUnary;
            opBr:
                instrClass = classBranch;
            opJr:
                instrClass = classJumpReg;
            opJal:
                instrClass = classJumpLink;
            opLd, opLdi:
                instrClass = classLoad;  // same address path for both
            opSt:
                instrClass = classStore;
            opMfhi:
                instrClass = classMoveHi;
            opMflo:
                instrClass = classMoveLo;
            opHalt:
                instrClass = classHalt;
            default:
                instrClass = classNone;  // back to fetch, no execute
        endcase
    end

    // operation for the computing step
    always_comb begin
        case (opcode)
            opAdd, opAddi,
            opLd, opLdi, opSt, opBr:
                decodedAluOp = aluAdd;   // address calc is base plus constant
            opSub:          decodedAluOp = aluSub;
            opAnd, opAndi:  decodedAluOp = aluAnd;
            opOr, opOri:    decodedAluOp = aluOr;
            opRor:          decodedAluOp = aluRor;
            opRol:          decodedAluOp = aluRol;
            opShr:          decodedAluOp = aluShr;
            opShra:         decodedAluOp = aluShra;
            opShl:          decodedAluOp = aluShl;
            opDiv:          decodedAluOp = aluDiv;
            opMul:          decodedAluOp = aluMul;
            opNeg:          decodedAluOp = aluNeg;
            opNot:          decodedAluOp = aluNot;
            default:        decodedAluOp = aluNone; // moves, jumps, halt
        endcase
    end

endmodule

`default_nettype wire

/* stepSequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module stepSequencer import cpuControlPkg::*; (
    input  wire logic       Clock,
    input  wire logic       Reset,
    input  wire instrClassT instrClass,   // decoder output, valid in fetch2
    input  wire aluOpT      decodedAluOp,
    output phaseT           phase,
    output stepT            step,
    output instrClassT      activeClass,  // held through execute
    output aluOpT           activeAluOp
);

    phaseT phaseNext;
    stepT  stepNext;
    stepT  lastStep;

    // index of the final execute step per class
    function automatic stepT lastStepOf(input instrClassT cls);
        case (cls)
            classAluReg, classAluImm,
            classMultiply, classUnary:
                lastStepOf = stepT'(2);  // 3 steps
            classDivide:
                lastStepOf = stepT'(3);  // extra step for hi and lo
            classBranch, classLoad, classStore:
                lastStepOf = stepT'(4);  // 5 steps
            classJumpLink:
                lastStepOf = stepT'(1);
            default:
                lastStepOf = stepT'(0);  // jr, mfhi, mflo
        endcase
    endfunction

    assign lastStep = lastStepOf(activeClass);

    always_comb begin
        phaseNext = phase;
        stepNext = '0;                        // step only counts inside exec
        case (phase)
            phaseReset:  phaseNext = phaseFetch0;
            phaseFetch0: phaseNext = phaseFetch1;
            phaseFetch1: phaseNext = phaseFetch2;
            phaseFetch2: begin
                case (instrClass)             // fresh decode, not yet latched
                    classHalt: phaseNext = phaseHalt;
                    classNone: phaseNext = phaseFetch0; // skip unknown opcode
                    default:   phaseNext = phaseExec;
                endcase
            end
            phaseExec: begin
                if (step == lastStep) begin
                    phaseNext = phaseFetch0;  // straight to next fetch
                end else begin
                    stepNext = step + stepT'(1);
                end
            end
            phaseHalt:   phaseNext = phaseHalt; // only reset leaves
            default:     phaseNext = phaseReset;
        endcase
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            phase <= phaseReset;
            step <= '0;
        end else begin
            phase <= phaseNext;
            step <= stepNext;
        end
    end

    // decode captured at the edge that ends fetch2
    always_ff @(posedge Clock) begin
        if (phase == phaseFetch2) begin
            activeClass <= instrClass;
            activeAluOp <= decodedAluOp;
        end
    end

endmodule

`default_nettype wire

/* controlWordGen.sv */
`timescale 1ns/100ps
`default_nettype none

module controlWordGen import cpuControlPkg::*; (
    input  wire phaseT      phase,
    input  wire stepT       step,
    input  wire instrClassT activeClass,
    input  wire aluOpT      activeAluOp,
    input  wire logic       conFlag,      // branch condition from datapath
    output logic            gra, grb, grc, rIn, rOut,
    output logic            run, clear, incPc,
    output logic            read, write,
    output logic            marIn, mdrIn, mdrOut, irIn,
    output logic            pcIn, pcOut, yIn, zIn,
    output logic            zHighIn, zLowIn, zHighOut, zLowOut,
    output logic            hiIn, loIn, hiOut, loOut,
    output logic            conIn, cOut,
    output aluOpT           aluOp
);

    always_comb begin
        {gra, grb, grc, rIn, rOut} = '0;
        {clear, incPc, read, write} = '0;
        {marIn, mdrIn, mdrOut, irIn} = '0;
        {pcIn, pcOut, yIn, zIn} = '0;
        {zHighIn, zLowIn, zHighOut, zLowOut} = '0;
        {hiIn, loIn, hiOut, loOut} = '0;
        {conIn, cOut} = '0;
        aluOp = aluNone;
        run = (phase != phaseHalt);           // drops only when halted

        case (phase)
            phaseReset: begin
                pcIn = 1'b1;                  // pc loads zero
                clear = 1'b1;
            end
            phaseFetch0: begin
                pcOut = 1'b1;
                marIn = 1'b1;                 // address of next instruction
                incPc = 1'b1;
            end
            phaseFetch1: begin
                read = 1'b1;
                mdrIn = 1'b1;
            end
            phaseFetch2: begin
                mdrOut = 1'b1;
                irIn = 1'b1;                  // instruction into ir
            end
            phaseExec: begin
                case (activeClass)
                    classAluReg, classAluImm, classDivide, classMultiply, classUnary: begin
                        case (step)
                            3'd0: begin
                                grb = 1'b1;   // rb into y
                                rOut = 1'b1;
                                yIn = 1'b1;
                            end
                            3'd1: begin
                                aluOp = activeAluOp; // compute step
                                if (activeClass == classAluImm) begin
                                    cOut = 1'b1;   // constant as second operand
                                end else if (activeClass != classUnary) begin
                                    grc = 1'b1;
                                    rOut = 1'b1;
                                end
                                if (activeClass == classDivide ||
                                    activeClass == classMultiply) begin
                                    zHighIn = 1'b1; // 64-bit result
                                    zLowIn = 1'b1;
                                end else begin
                                    zIn = 1'b1;
                                end
                            end
                            3'd2: begin
                                if (activeClass == classDivide) begin
                                    zHighOut = 1'b1; // remainder to hi
                                    hiIn = 1'b1;
                                end else begin
                                    zLowOut = 1'b1;  // result to ra
                                    gra = 1'b1;
                                    rIn = 1'b1;
                                end
                            end
                            3'd3: begin
                                zLowOut = 1'b1;      // quotient to lo
                                loIn = 1'b1;
                            end
                            default: ;
                        endcase
                    end
                    classBranch: begin
                        case (step)
                            3'd0: begin
                                gra = 1'b1;   // ra tested by con logic
                                rOut = 1'b1;
                                conIn = 1'b1;
                            end
                            3'd1: begin
                                pcOut = 1'b1;
                                yIn = 1'b1;
                            end
                            3'd2: begin
                                cOut = 1'b1;  // target = pc plus offset
                                aluOp = activeAluOp;
                                zIn = 1'b1;
                            end
                            3'd3: begin
                                zLowOut = conFlag;
                                incPc = !conFlag; // not taken
                            end
                            3'd4: pcIn = conFlag; // taken loads target
                            default: ;
                        endcase
                    end
                    classLoad, classStore: begin
                        case (step)
                            3'd0: begin
                                grb = 1'b1;   // base register
                                rOut = 1'b1;
                                yIn = 1'b1;
                            end
                            3'd1: begin
                                cOut = 1'b1;
                                aluOp = activeAluOp;
                                zIn = 1'b1;
                            end
                            3'd2: begin
                                zLowOut = 1'b1; // effective address
                                marIn = 1'b1;
                            end
                            3'd3: begin
                                mdrIn = 1'b1;
                                if (activeClass == classLoad) begin
                                    read = 1'b1;
                                end else begin
                                    gra = 1'b1; // store data from ra
                                    rOut = 1'b1;
                                end
                            end
                            3'd4: begin
                                if (activeClass == classLoad) begin
                                    mdrOut = 1'b1;
                                    gra = 1'b1;
                                    rIn = 1'b1;
                                end else begin
                                    write = 1'b1;
                                end
                            end
                            default: ;
                        endcase
                    end
                    classJumpReg: begin
                        gra = 1'b1;
                        rOut = 1'b1;
                        pcIn = 1'b1;
                    end
                    classJumpLink: begin
                        if (step == 3'd0) begin
                            pcOut = 1'b1;     // return address into link reg
                            grb = 1'b1;
                            rIn = 1'b1;
                        end else begin
                            gra = 1'b1;
                            rOut = 1'b1;
                            pcIn = 1'b1;
                        end
                    end
                    classMoveHi: begin
                        hiOut = 1'b1;
                        gra = 1'b1;
                        rIn = 1'b1;
                    end
                    classMoveLo: begin
                        loOut = 1'b1;
                        gra = 1'b1;
                        rIn = 1'b1;
                    end
                    default: ;
                endcase
            end
            default: ;                        // halt drives nothing
        endcase
    end

endmodule

`default_nettype wire

/* controlUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module controlUnit import cpuControlPkg::*; #(
    parameter int InstrWidth = InstrWidthDefault
) (
    input  wire logic                  Clock,
    input  wire logic                  Reset,
    input  wire logic [InstrWidth-1:0] instruction, // ir contents from datapath
    input  wire logic                  conFlag,
    output logic                       gra, grb, grc, rIn, rOut,
    output logic                       run, clear, incPc,
    output logic                       read, write,
    output logic                       marIn, mdrIn, mdrOut, irIn,
    output logic                       pcIn, pcOut, yIn, zIn,
    output logic                       zHighIn, zLowIn, zHighOut, zLowOut,
    output logic                       hiIn, loIn, hiOut, loOut,
    output logic                       conIn, cOut,
    output aluOpT                      aluOp
);

    instrClassT instrClass;
    instrClassT activeClass;
    aluOpT      decodedAluOp;
    aluOpT      activeAluOp;
    phaseT      phase;
    stepT       step;

    opcodeDecoder #(
        .InstrWidth(InstrWidth)
    ) u_opcodeDecoder (
        .instruction(instruction),
        .instrClass(instrClass),
        .decodedAluOp(decodedAluOp)
    );

    stepSequencer u_stepSequencer (
        .Clock(Clock),
        .Reset(Reset),
        .instrClass(instrClass),
        .decodedAluOp(decodedAluOp),
        .phase(phase),
        .step(step),
        .activeClass(activeClass),
        .activeAluOp(activeAluOp)
    );

    controlWordGen u_controlWordGen (
        .phase(phase), .step(step), .activeClass(activeClass),
        .activeAluOp(activeAluOp), .conFlag(conFlag),
        .gra(gra), .grb(grb), .grc(grc), .rIn(rIn), .rOut(rOut),
        .run(run), .clear(clear), .incPc(incPc), .read(read), .write(write),
        .marIn(marIn), .mdrIn(mdrIn), .mdrOut(mdrOut), .irIn(irIn),
        .pcIn(pcIn), .pcOut(pcOut), .yIn(yIn), .zIn(zIn),
        .zHighIn(zHighIn), .zLowIn(zLowIn), .zHighOut(zHighOut), .zLowOut(zLowOut),
        .hiIn(hiIn), .loIn(loIn), .hiOut(hiOut), .loOut(loOut),
        .conIn(conIn), .cOut(cOut), .aluOp(aluOp)
    );

endmodule

`default_nettype wire

/* controlUnit_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module controlUnitProperties import cpuControlPkg::*; (
    input wire logic  Clock,
    input wire logic  Reset,
    input wire logic  read,
    input wire logic  write,
    input wire logic  rIn,
    input wire logic  rOut,
    input wire logic  run,
    input wire logic  mdrIn,
    input wire logic  irIn,
    input wire phaseT phase   // internal sequencer phase
);

    // one direction on the memory bus per cycle
    readWriteExclusive: assert property (@(posedge Clock) disable iff (Reset)
        !(read && write))
        else $error("read and write high in the same cycle");

    // register file drives or loads, never both
    regFileExclusive: assert property (@(posedge Clock) disable iff (Reset)
        !(rIn && rOut))
        else $error("rIn and rOut high in the same cycle");

    // halted cpu stays halted
    haltSticky: assert property (@(posedge Clock) disable iff (Reset)
        !run |=> !run)
        else $error("run rose again without a reset");

    // fetch read is always followed by the ir load
    fetchLoadsIr: assert property (@(posedge Clock) disable iff (Reset)
        (mdrIn && phase == phaseFetch1) |=> irIn)
        else $error("irIn missing one cycle after fetch mdrIn");

    // and ir loads at no other time
    irOnlyAfterFetch: assert property (@(posedge Clock) disable iff (Reset)
        irIn |-> $past(mdrIn && phase == phaseFetch1))
        else $error("irIn high without a fetch mdrIn just before");

endmodule

bind controlUnit controlUnitProperties u_controlUnitProperties (
    .Clock(Clock),
    .Reset(Reset),
    .read(read),
    .write(write),
    .rIn(rIn),
    .rOut(rOut),
    .run(run),
    .mdrIn(mdrIn),
    .irIn(irIn),
    .phase(phase)
);

`default_nettype wire

/* controlUnitTb.sv */
`timescale 1ns/100ps
`default_nettype none

module controlUnitTb import cpuControlPkg::*; ();

    localparam int ResetCycles = 8;
    localparam int BranchTrials = 6;
    localparam int HaltWatch = 20;             // cycles watched after halt
    localparam int LowBits = InstrWidthDefault - OpcodeWidth;
    // two reset tests, alu, div/mul/neg/not, branches, memory and jumps, halt
    localparam int CycleLimit = 2 * (ResetCycles + 4) + 12 * 6 + 25
                                + BranchTrials * 8 + 41 + 3 + HaltWatch + 40;
    localparam opcodeT opUnknown = 5'b11111;   // not decoded

    typedef logic [27:0] strobeT;

    // one bit per strobe, same order as the strobes vector
    localparam strobeT sCOut     = strobeT'(1) << 0;
    localparam strobeT sConIn    = strobeT'(1) << 1;
    localparam strobeT sLoOut    = strobeT'(1) << 2;
    localparam strobeT sHiOut    = strobeT'(1) << 3;
    localparam strobeT sLoIn     = strobeT'(1) << 4;
    localparam strobeT sHiIn     = strobeT'(1) << 5;
    localparam strobeT sZLowOut  = strobeT'(1) << 6;
    localparam strobeT sZHighOut = strobeT'(1) << 7;
    localparam strobeT sZLowIn   = strobeT'(1) << 8;
    localparam strobeT sZHighIn  = strobeT'(1) << 9;
    localparam strobeT sZIn      = strobeT'(1) << 10;
    localparam strobeT sYIn      = strobeT'(1) << 11;
    localparam strobeT sPcOut    = strobeT'(1) << 12;
    localparam strobeT sPcIn     = strobeT'(1) << 13;
    localparam strobeT sIrIn     = strobeT'(1) << 14;
    localparam strobeT sMdrOut   = strobeT'(1) << 15;
    localparam strobeT sMdrIn    = strobeT'(1) << 16;
    localparam strobeT sMarIn    = strobeT'(1) << 17;
    localparam strobeT sWrite    = strobeT'(1) << 18;
    localparam strobeT sRead     = strobeT'(1) << 19;
    localparam strobeT sIncPc    = strobeT'(1) << 20;
    localparam strobeT sClear    = strobeT'(1) << 21;
    localparam strobeT sRun      = strobeT'(1) << 22;
    localparam strobeT sROut     = strobeT'(1) << 23;
    localparam strobeT sRIn      = strobeT'(1) << 24;
    localparam strobeT sGrc      = strobeT'(1) << 25;
    localparam strobeT sGrb      = strobeT'(1) << 26;
    localparam strobeT sGra      = strobeT'(1) << 27;

    logic Clock;
    logic Reset;
    logic [InstrWidthDefault-1:0] instruction;
    logic conFlag;
    logic gra, grb, grc, rIn, rOut, run, clear, incPc, read, write;
    logic marIn, mdrIn, mdrOut, irIn, pcIn, pcOut, yIn, zIn;
    logic zHighIn, zLowIn, zHighOut, zLowOut, hiIn, loIn, hiOut, loOut, conIn, cOut;
    aluOpT aluOp;
    strobeT strobes;

    int checkCount = 0;
    int errorCount = 0;
    int testCount = 0;
    int errorMark = 0;
    int cycleCount = 0;

    string strobeNames [28] = '{"cOut", "conIn", "loOut", "hiOut", "loIn", "hiIn",
        "zLowOut", "zHighOut", "zLowIn", "zHighIn", "zIn", "yIn", "pcOut", "pcIn",
        "irIn", "mdrOut", "mdrIn", "marIn", "write", "read", "incPc", "clear", "run",
        "rOut", "rIn", "grc", "grb", "gra"};

    // register forms first, the last three are immediates
    opcodeT aluOpcodes [12] = '{opAdd, opSub, opAnd, opOr, opRor, opRol, opShr,
        opShra, opShl, opAddi, opAndi, opOri};
    aluOpT aluResults [12] = '{aluAdd, aluSub, aluAnd, aluOr, aluRor, aluRol, aluShr,
        aluShra, aluShl, aluAdd, aluAnd, aluOr};

    assign strobes = {gra, grb, grc, rIn, rOut, run, clear, incPc, read, write,
                      marIn, mdrIn, mdrOut, irIn, pcIn, pcOut, yIn, zIn,
                      zHighIn, zLowIn, zHighOut, zLowOut, hiIn, loIn, hiOut, loOut,
                      conIn, cOut};

    controlUnit #(
        .InstrWidth(InstrWidthDefault)
    ) u_controlUnit (.*);

    always #50 Clock = ~Clock;                 // 100 ns period

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("timeout: run went past %0d cycles", CycleLimit);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic checkValue(input string name, input int actual, input int expected);
        checkCount++;
        if (actual != expected) begin
            errorCount++;
            $display("FAILED t=%0t %s got %0d expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic checkCycle(input strobeT expStrobes, input aluOpT expOp);
        for (int i = 0; i < 28; i++) begin
            checkValue(strobeNames[i], int'(strobes[i]), int'(expStrobes[i]));
        end
        checkValue("aluOp", int'(aluOp), int'(expOp));
    endtask

    task automatic execStep(input strobeT expStrobes, input aluOpT expOp);
        checkCycle(sRun | expStrobes, expOp); // run stays up outside halt
        @(negedge Clock);
    endtask

    // starts in the fetch0 cycle, ends in the first execute cycle
    task automatic fetchWith(input opcodeT op);
        checkCycle(sRun | sPcOut | sMarIn | sIncPc, aluNone);
        @(negedge Clock);
        checkCycle(sRun | sRead | sMdrIn, aluNone);
        @(negedge Clock);
        instruction = {op, LowBits'($urandom)}; // held across the fetch2 edge
        checkCycle(sRun | sMdrOut | sIrIn, aluNone);
        @(negedge Clock);
    endtask

    task automatic startTest();
        errorMark = errorCount;
    endtask

    task automatic finishTest(input string name);
        testCount++;
        $display("test %-8s %0d errors", name, errorCount - errorMark);
    endtask

    task automatic resetTest();
        startTest();
        Reset = 1'b1;
        repeat (ResetCycles) @(negedge Clock);
        Reset = 1'b0;
        checkCycle(sRun | sClear | sPcIn, aluNone); // reset step, pc cleared
        @(negedge Clock);
        fetchWith(opUnknown);                    // no execute, back to fetch0
        finishTest("reset");
    endtask

    task automatic aluTest();
        int order [12];
        int pick;
        int tmp;
        int k;
        startTest();
        for (int i = 0; i < 12; i++) begin
            order[i] = i;
        end
        for (int i = 11; i > 0; i--) begin      // shuffle opcode order
            pick = int'($urandom % (i + 1));
            tmp = order[i];
            order[i] = order[pick];
            order[pick] = tmp;
        end
        for (int i = 0; i < 12; i++) begin
            k = order[i];
            fetchWith(aluOpcodes[k]);
            execStep(sGrb | sROut | sYIn, aluNone);
            execStep((k >= 9) ? (sCOut | sZIn) : (sGrc | sROut | sZIn), aluResults[k]);
            execStep(sZLowOut | sGra | sRIn, aluNone);
        end
        finishTest("alu");
    endtask

    task automatic hiLoTest();
        startTest();
        fetchWith(opDiv);
        execStep(sGrb | sROut | sYIn, aluNone);
        execStep(sGrc | sROut | sZHighIn | sZLowIn, aluDiv);
        execStep(sZHighOut | sHiIn, aluNone);   // remainder
        execStep(sZLowOut | sLoIn, aluNone);    // quotient
        fetchWith(opMul);
        execStep(sGrb | sROut | sYIn, aluNone);
        execStep(sGrc | sROut | sZHighIn | sZLowIn, aluMul);
        execStep(sZLowOut | sGra | sRIn, aluNone);
        fetchWith(opNeg);
        execStep(sGrb | sROut | sYIn, aluNone);
        execStep(sZIn, aluNeg);                 // single operand
        execStep(sZLowOut | sGra | sRIn, aluNone);
        fetchWith(opNot);
        execStep(sGrb | sROut | sYIn, aluNone);
        execStep(sZIn, aluNot);
        execStep(sZLowOut | sGra | sRIn, aluNone);
        finishTest("hilo");
    endtask

    task automatic branchTest();
        logic flag;
        startTest();
        for (int i = 0; i < BranchTrials; i++) begin
            flag = 1'($urandom);
            fetchWith(opBr);
            conFlag = flag;
            execStep(sGra | sROut | sConIn, aluNone);
            execStep(sPcOut | sYIn, aluNone);
            execStep(sCOut | sZIn, aluAdd);
            execStep(flag ? sZLowOut : sIncPc, aluNone);
            execStep(flag ? sPcIn : '0, aluNone);
        end
        finishTest("branch");
    endtask

    task automatic memSteps(input logic isLoad);
        execStep(sGrb | sROut | sYIn, aluNone);
        execStep(sCOut | sZIn, aluAdd);         // base plus offset
        execStep(sZLowOut | sMarIn, aluNone);
        execStep(isLoad ? (sRead | sMdrIn) : (sMdrIn | sGra | sROut), aluNone);
        execStep(isLoad ? (sMdrOut | sGra | sRIn) : sWrite, aluNone);
    endtask

    task automatic memJumpTest();
        startTest();
        fetchWith(opLd);
        memSteps(1'b1);
        fetchWith(opLdi);
        memSteps(1'b1);
        fetchWith(opSt);
        memSteps(1'b0);
        fetchWith(opJr);
        execStep(sGra | sROut | sPcIn, aluNone);
        fetchWith(opJal);
        execStep(sPcOut | sGrb | sRIn, aluNone); // link first
        execStep(sGra | sROut | sPcIn, aluNone);
        fetchWith(opMfhi);
        execStep(sHiOut | sGra | sRIn, aluNone);
        fetchWith(opMflo);
        execStep(sLoOut | sGra | sRIn, aluNone);
        finishTest("memjump");
    endtask

    task automatic haltTest();
        startTest();
        fetchWith(opHalt);
        repeat (HaltWatch) begin
            checkCycle('0, aluNone);            // run low, no fetch
            @(negedge Clock);
        end
        finishTest("halt");
    endtask

    initial begin
        void'($urandom(36));
        Clock = 1'b0;
        Reset = 1'b1;
        instruction = '0;
        conFlag = 1'b0;
        resetTest();
        aluTest();
        hiLoTest();
        branchTest();
        memJumpTest();
        haltTest();
        resetTest();                            // restart after halt
        $display("tests %0d checks %0d errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
cpuControlPkg.sv
opcodeDecoder.sv
stepSequencer.sv
controlWordGen.sv
controlUnit.sv
controlUnit_properties.sv
controlUnitTb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := controlUnitTb
FILELIST := project.f
OBJ      := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ)

run: build
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q '\*\* PASS \*\*' $(LOG)

lint:
	$(SIM) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ) $(LOG)
